/* uart_top.f */
+incdir+include
source/uart_pkg.sv
source/uart_fifo_if.sv
source/uart_fifo.sv
source/uart_regs.sv
source/uart_baud_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_top.sv
tb/uart_asserts.sv
tb/uart_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the UART testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f uart_top.f --top-module uart_tb || exit 1

./obj_dir/Vuart_tb 2>&1 | tee /dev/stderr | grep -q "^Test OK$" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

/* tb/uart_tb.sv */
`include "uart_consts.svh"

module uart_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int Depth = `UART_FIFO_DEPTH;
	localparam int BusLimit = 20;		// clocks per handshake phase
	localparam int WaitLimit = 4000;	// clocks or status polls

	logic clk_i = 1'b0;
	logic rst_i;
	logic req_i;
	logic ack_o;
	logic we_i;
	logic [1:0] adr_i;
	logic [7:0] dat_i;
	logic [7:0] dat_o;
	logic rxd_i;
	logic txd_o;

	logic [7:0] curDiv;		// divisor last written
	logic parEn;
	logic parOdd;
	logic loopOn;			// loopback bit last written
	logic [7:0] sent[$];	// bytes expected back in send order

	// pending checks for the compare process
	string nameQ[$];
	logic [15:0] gotQ[$];
	logic [15:0] expQ[$];

	uart_top i_uart_top (.*);

	always #20 clk_i = ~clk_i;	// 40 ns period

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic expectEq(input string name, input logic [15:0] got, input logic [15:0] exp);
		nameQ.push_back(name);
		gotQ.push_back(got);
		expQ.push_back(exp);
	endtask

	// drain queued checks in order
	always @(negedge clk_i) begin
		while (gotQ.size() != 0) begin
			assert (gotQ[0] == expQ[0]) else
				stopWithFailure($sformatf("MISMATCH %s got 0x%0h expected 0x%0h",
					nameQ[0], gotQ[0], expQ[0]));
			nameQ.delete(0);
			gotQ.delete(0);
			expQ.delete(0);
		end
	end

	// pin stays high while looped back
	always @(negedge clk_i) begin
		if (loopOn)
			assert (txd_o === 1'b1) else
				stopWithFailure($sformatf("MISMATCH txd_o got 0x%0h expected 0x1", txd_o));
	end

	task automatic waitClocks(input int n);
		repeat (n) @(negedge clk_i);
	endtask

	// ----------------------------------------
	// four-phase bus master entered on a falling edge
	task automatic busAccess(input logic we, input logic [1:0] adr, input logic [7:0] wdata,
		output logic [7:0] rdata);
		int n;
		n = 0;
		req_i = 1'b1;
		we_i = we;
		adr_i = adr;
		dat_i = wdata;
		while (ack_o !== 1'b1 && n < BusLimit) begin
			@(negedge clk_i);
			n++;
		end
		assert (ack_o === 1'b1) else stopWithFailure("bus ack never rose");
		rdata = dat_o;		// valid while ack high
		req_i = 1'b0;
		n = 0;
		while (ack_o !== 1'b0 && n < BusLimit) begin
			@(negedge clk_i);
			n++;
		end
		assert (ack_o === 1'b0) else stopWithFailure("bus ack never fell");
	endtask

	task automatic busWrite(input logic [1:0] adr, input logic [7:0] data);
		logic [7:0] unused;
		busAccess(1'b1, adr, data, unused);
	endtask

	task automatic busRead(input logic [1:0] adr, output logic [7:0] data);
		busAccess(1'b0, adr, 8'h00, data);
	endtask

	// poll STAT until one bit is set
	task automatic waitStatus(input int bitPos, output logic [7:0] stat);
		int n;
		n = 0;
		busRead(`UART_ADDR_STAT, stat);
		while (!stat[bitPos] && n < WaitLimit) begin
			busRead(`UART_ADDR_STAT, stat);
			n++;
		end
		assert (stat[bitPos]) else stopWithFailure($sformatf("status bit %0d never set", bitPos));
	endtask

	task automatic setFormat(input logic pe, input logic po, input logic lp);
		logic [7:0] cmd;
		cmd = '0;
		cmd[`UART_CMD_PAREN] = pe;
		cmd[`UART_CMD_PARODD] = po;
		cmd[`UART_CMD_LOOP] = lp;
		parEn = pe;
		parOdd = po;
		busWrite(`UART_ADDR_CMD, cmd);
		loopOn = lp;
	endtask

	// ----------------------------------------
	// reference model of a frame
	function automatic logic parityBit(input logic [7:0] data, input logic odd);
		return ^data ^ odd;		// total ones even or odd
	endfunction

	function automatic logic [10:0] frameBits(input logic [7:0] data, input logic pe,
		input logic po);
		logic [10:0] f;
		f = '1;		// stop and idle high
		f[0] = 1'b0;
		f[8:1] = data;	// lsb first
		if (pe)
			f[9] = parityBit(data, po);
		return f;
	endfunction

	function automatic int bitClocks();
		return (int'(curDiv) + 1) * `UART_OVERSAMPLE;
	endfunction

	// serial line model
	task automatic sendFrame(input logic [7:0] data, input logic flipPar, input logic badStop);
		logic [10:0] bits;
		int len;
		bits = frameBits(data, parEn, parOdd);
		len = parEn ? 11 : 10;
		if (flipPar)
			bits[9] = ~bits[9];
		if (badStop)
			bits[len - 1] = 1'b0;
		for (int i = 0; i < len; i++) begin
			rxd_i = bits[i];
			waitClocks(bitClocks());
		end
		rxd_i = 1'b1;
		waitClocks(bitClocks());	// idle gap
	endtask

	task automatic captureFrame(output logic [10:0] bits);
		int n;
		n = 0;
		bits = '1;
		while (txd_o !== 1'b0 && n < WaitLimit) begin
			@(negedge clk_i);
			n++;
		end
		assert (txd_o === 1'b0) else stopWithFailure("no start bit on txd_o");
		waitClocks(bitClocks() / 2);	// to mid start bit
		for (int i = 0; i < (parEn ? 11 : 10); i++) begin
			bits[i] = txd_o;
			waitClocks(bitClocks());
		end
	endtask

	task automatic checkRxEntry(input logic [7:0] data, input logic perr, input logic ferr);
		logic [7:0] rd;
		waitStatus(`UART_STAT_RXRDY, rd);
		expectEq("dat_o STAT.PERR", 16'(rd[`UART_STAT_PERR]), 16'(perr));	// before the pop
		expectEq("dat_o STAT.FERR", 16'(rd[`UART_STAT_FERR]), 16'(ferr));
		busRead(`UART_ADDR_DATA, rd);
		expectEq("dat_o DATA", 16'(rd), 16'(data));
	endtask

	// ----------------------------------------
	initial begin
		logic [7:0] b;
		logic [7:0] rd;
		logic [10:0] bits;
		int n;
		void'($urandom(31));
		rst_i = 1'b1;
		req_i = 1'b0;
		we_i = 1'b0;
		adr_i = '0;
		dat_i = '0;
		rxd_i = 1'b1;	// line idle
		curDiv = `UART_DIV_RESET;
		parEn = 1'b0;
		parOdd = 1'b0;
		loopOn = 1'b0;
		waitClocks(3);
		rst_i = 1'b0;

		// register values after reset
		busRead(`UART_ADDR_STAT, rd);
		expectEq("dat_o STAT", 16'(rd), 16'(1 << `UART_STAT_TXIDLE));
		busRead(`UART_ADDR_CMD, rd);
		expectEq("dat_o CMD", 16'(rd), 16'h0);
		busRead(`UART_ADDR_DIV, rd);
		expectEq("dat_o DIV", 16'(rd), 16'(`UART_DIV_RESET));

		// loopback with no parity then even then odd
		for (int fmt = 0; fmt < 3; fmt++) begin
			setFormat(fmt != 0, fmt == 2, 1'b1);
			n = 1 + int'($urandom % Depth);
			for (int i = 0; i < n; i++) begin
				b = 8'($urandom);
				sent.push_back(b);
				busWrite(`UART_ADDR_DATA, b);
			end
			while (sent.size() != 0)
				checkRxEntry(sent.pop_front(), 1'b0, 1'b0);
			waitStatus(`UART_STAT_TXIDLE, rd);
		end

		// frames seen on txd_o at a random rate
		curDiv = 8'(1 + $urandom % 7);
		busWrite(`UART_ADDR_DIV, curDiv);
		for (int fmt = 0; fmt < 3; fmt++) begin
			setFormat(fmt != 0, fmt == 2, 1'b0);
			for (int i = 0; i < 3; i++) begin
				b = 8'($urandom);
				busWrite(`UART_ADDR_DATA, b);
				captureFrame(bits);
				expectEq("txd_o frame", 16'(bits), 16'(frameBits(b, parEn, parOdd)));
			end
		end

		// even parity receive of a clean frame then bad parity then bad stop
		setFormat(1'b1, 1'b0, 1'b0);
		b = 8'($urandom);
		sendFrame(b, 1'b0, 1'b0);
		checkRxEntry(b, 1'b0, 1'b0);
		b = 8'($urandom);
		sendFrame(b, 1'b1, 1'b0);
		checkRxEntry(b, 1'b1, 1'b0);
		b = 8'($urandom);
		sendFrame(b, 1'b0, 1'b1);
		checkRxEntry(b, 1'b0, 1'b1);

		// overrun with one frame more than the fifo holds
		setFormat(1'b0, 1'b0, 1'b0);
		for (int i = 0; i <= Depth; i++) begin
			b = 8'($urandom);
			sent.push_back(b);
			sendFrame(b, 1'b0, 1'b0);
		end
		busRead(`UART_ADDR_STAT, rd);
		expectEq("dat_o STAT.OVR", 16'(rd[`UART_STAT_OVR]), 16'h1);
		void'(sent.pop_back());		// last one lost
		while (sent.size() != 0)
			checkRxEntry(sent.pop_front(), 1'b0, 1'b0);
		busWrite(`UART_ADDR_STAT, 8'h00);
		busRead(`UART_ADDR_STAT, rd);
		expectEq("dat_o STAT", 16'(rd), 16'(1 << `UART_STAT_TXIDLE));

		// fifo clear with both fifos holding data
		b = 8'($urandom);
		sendFrame(b, 1'b0, 1'b0);
		waitStatus(`UART_STAT_RXRDY, rd);
		for (int i = 0; i <= Depth; i++)
			busWrite(`UART_ADDR_DATA, 8'(i));	// first one goes straight to the shifter
		busRead(`UART_ADDR_STAT, rd);
		expectEq("dat_o STAT.TXFULL", 16'(rd[`UART_STAT_TXFULL]), 16'h1);
		busWrite(`UART_ADDR_CMD, 8'(1 << `UART_CMD_FIFOCLR));
		busRead(`UART_ADDR_STAT, rd);
		expectEq("dat_o STAT.RXRDY", 16'(rd[`UART_STAT_RXRDY]), 16'h0);
		expectEq("dat_o STAT.TXFULL", 16'(rd[`UART_STAT_TXFULL]), 16'h0);
		busRead(`UART_ADDR_DATA, rd);
		expectEq("dat_o DATA", 16'(rd), 16'h0);	// empty reads zero
		busRead(`UART_ADDR_CMD, rd);
		expectEq("dat_o CMD", 16'(rd), 16'h0);

		n = 0;
		while (gotQ.size() != 0 && n < BusLimit) begin
			@(negedge clk_i);
			n++;
		end
		if (gotQ.size() == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			stopWithFailure("compare queue never drained");
		end
	end
endmodule

/* tb/uart_asserts.sv */
module uart_asserts (
	input logic clk_i,
	input logic rst_i,
	input logic req_i,
	input logic ack_i,
	input logic txIdle_i,
	input logic txd_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// ----------------------------------------
	// four-phase handshake
	ackNeedsReq: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(ack_i) |-> $past(req_i))
		else $error("ack rose with no request");

	ackHeldWithReq: assert property (@(posedge clk_i) disable iff (rst_i)
		req_i && ack_i |=> ack_i)
		else $error("ack fell while request high");

	// serial line idles high
	lineIdleHigh: assert property (@(posedge clk_i) disable iff (rst_i)
		txIdle_i |-> txd_i)
		else $error("txd low while transmitter idle");
endmodule

bind uart_regs uart_asserts i_regsAsserts (
	.clk_i(clk_i), .rst_i(rst_i), .req_i(req_i), .ack_i(ack_o),
	.txIdle_i(1'b0), .txd_i(1'b1)	// no line here
);

bind uart_top uart_asserts i_topAsserts (
	.clk_i(clk_i), .rst_i(rst_i), .req_i(req_i), .ack_i(ack_o),
	.txIdle_i(txIdle), .txd_i(txd_o)
);

/* source/uart_top.sv */
module uart_top (
	input logic clk_i,
	input logic rst_i,
	input logic req_i,
	output logic ack_o,
	input logic we_i,
	input logic [1:0] adr_i,
	input uart_pkg::byte_t dat_i,
	output uart_pkg::byte_t dat_o,
	input logic rxd_i,
	output logic txd_o
);
	uart_pkg::frame_cfg_t cfg;
	uart_pkg::byte_t divisor;
	logic divRestart;
	logic tick;
	logic loop;
	logic txIdle;
	logic overrun;
	logic txLine;		// raw tx output
	logic rxLine;		// rx input after loopback mux

	uart_fifo_if #(.entry_t(uart_pkg::byte_t)) txFifoIf ();
	uart_fifo_if #(.entry_t(uart_pkg::rx_entry_t)) rxFifoIf ();

	// ----------------------------------------
	// loopback, tx feeds rx and the pin idles
	assign rxLine = loop ? txLine : rxd_i;
	assign txd_o = loop ? 1'b1 : txLine;

	uart_regs i_uart_regs (
		.clk_i(clk_i), .rst_i(rst_i),
		.req_i(req_i), .ack_o(ack_o), .we_i(we_i), .adr_i(adr_i),
		.dat_i(dat_i), .dat_o(dat_o),
		.txIdle_i(txIdle), .overrun_i(overrun),
		.txFifo(txFifoIf.writer), .rxFifo(rxFifoIf.reader),
		.cfg_o(cfg), .loop_o(loop),
		.divisor_o(divisor), .divRestart_o(divRestart)
	);

	uart_baud_gen i_uart_baud_gen (
		.clk_i(clk_i), .rst_i(rst_i),
		.divisor_i(divisor), .restart_i(divRestart), .tick_o(tick)
	);

	// fifos, one per direction
	uart_fifo #(.entry_t(uart_pkg::byte_t)) i_txFifo (
		.clk_i(clk_i), .rst_i(rst_i), .f(txFifoIf.fifo)
	);

	uart_fifo #(.entry_t(uart_pkg::rx_entry_t)) i_rxFifo (
		.clk_i(clk_i), .rst_i(rst_i), .f(rxFifoIf.fifo)
	);

	uart_tx i_uart_tx (
		.clk_i(clk_i), .rst_i(rst_i), .tick_i(tick), .cfg_i(cfg),
		.fifo(txFifoIf.reader), .txd_o(txLine), .idle_o(txIdle)
	);

	uart_rx i_uart_rx (
		.clk_i(clk_i), .rst_i(rst_i), .tick_i(tick), .cfg_i(cfg),
		.rxd_i(rxLine), .fifo(rxFifoIf.writer), .overrun_o(overrun)
	);
endmodule

/* source/uart_rx.sv */
`include "uart_consts.svh"

module uart_rx (
	input logic clk_i,
	input logic rst_i,
	input logic tick_i,
	input uart_pkg::frame_cfg_t cfg_i,
	input logic rxd_i,
	uart_fifo_if.writer fifo,
	output logic overrun_o		// byte lost, fifo full
);
	localparam int Os = `UART_OVERSAMPLE;
	localparam int CntW = $clog2(Os);

	uart_pkg::rx_state_t state;
	logic rxMeta;
	logic rxSync;
	logic rxPrev;
	logic fall;
	logic [CntW-1:0] tickCnt;
	logic sampleNow;	// mid bit
	logic [2:0] bitIdx;
	uart_pkg::byte_t shiftReg;
	logic parAcc;
	logic parErr;
	uart_pkg::rx_entry_t entry;

	// ----------------------------------------
	// line synchronizer, edge detect
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end else begin
			rxMeta <= rxd_i;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
		end
	end

	assign fall = rxPrev & ~rxSync;

	// half a bit to the start centre, then whole bits
	assign sampleNow = tick_i && (state == uart_pkg::RxStart ?
		tickCnt == CntW'(Os / 2 - 1) : tickCnt == CntW'(Os - 1));

	always_ff @(posedge clk_i) begin
		if (rst_i || state == uart_pkg::RxIdle)
			tickCnt <= '0;
		else if (tick_i)
			tickCnt <= sampleNow ? '0 : tickCnt + 1'b1;
	end

	// ----------------------------------------
	// bit sequencer
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= uart_pkg::RxIdle;
			bitIdx <= '0;
		end else begin
			case (state)
				uart_pkg::RxIdle: if (fall) state <= uart_pkg::RxStart;
				uart_pkg::RxStart: if (sampleNow) begin
					state <= rxSync ? uart_pkg::RxIdle : uart_pkg::RxData;	// glitch rejected
					bitIdx <= '0;
				end
				uart_pkg::RxData: if (sampleNow) begin
					bitIdx <= bitIdx + 1'b1;
					if (bitIdx == 3'd7)
						state <= cfg_i.parEn ? uart_pkg::RxParity : uart_pkg::RxStop;
				end
				uart_pkg::RxParity: if (sampleNow) state <= uart_pkg::RxStop;
				uart_pkg::RxStop: if (sampleNow) state <= uart_pkg::RxIdle;
				default: state <= uart_pkg::RxIdle;
			endcase
		end
	end

	// data and parity check
	always_ff @(posedge clk_i) begin
		if (state == uart_pkg::RxStart && sampleNow) begin
			parAcc <= cfg_i.parOdd;
			parErr <= 1'b0;		// stays clear without parity
		end
		if (state == uart_pkg::RxData && sampleNow) begin
			shiftReg <= {rxSync, shiftReg[7:1]};	// lsb arrives first
			parAcc <= parAcc ^ rxSync;
		end
		if (state == uart_pkg::RxParity && sampleNow)
			parErr <= parAcc ^ rxSync;
	end

	// push after the stop sample
	always_comb begin
		entry.data = shiftReg;
		entry.perr = parErr;
		entry.ferr = ~rxSync;	// stop bit low
	end

	assign fifo.push = state == uart_pkg::RxStop && sampleNow;
	assign fifo.wrData = entry;
	assign overrun_o = fifo.push & fifo.full;
endmodule

/* source/uart_tx.sv */
`include "uart_consts.svh"

module uart_tx (
	input logic clk_i,
	input logic rst_i,
	input logic tick_i,
	input uart_pkg::frame_cfg_t cfg_i,
	uart_fifo_if.reader fifo,
	output logic txd_o,
	output logic idle_o
);
	localparam int Os = `UART_OVERSAMPLE;
	localparam int CntW = $clog2(Os);

	uart_pkg::tx_state_t state;
	logic [CntW-1:0] tickCnt;
	logic [2:0] bitIdx;
	logic bitDone;
	uart_pkg::byte_t shiftReg;
	logic parAcc;		// running parity

	assign fifo.pop = state == uart_pkg::TxIdle && !fifo.empty;
	assign idle_o = state == uart_pkg::TxIdle && fifo.empty;	// nothing left to send
	assign bitDone = tick_i && tickCnt == CntW'(Os - 1);

	// ticks within the current bit
	always_ff @(posedge clk_i) begin
		if (rst_i || state == uart_pkg::TxIdle || state == uart_pkg::TxWait)
			tickCnt <= '0;
		else if (tick_i)
			tickCnt <= bitDone ? '0 : tickCnt + 1'b1;
	end

	// ----------------------------------------
	// frame sequencer
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= uart_pkg::TxIdle;
			txd_o <= 1'b1;		// line idles high
			bitIdx <= '0;
		end else begin
			case (state)
				uart_pkg::TxIdle: if (!fifo.empty) state <= uart_pkg::TxWait;
				uart_pkg::TxWait: if (tick_i) begin	// align to tick
					state <= uart_pkg::TxStart;
					txd_o <= 1'b0;
				end
				uart_pkg::TxStart: if (bitDone) begin
					state <= uart_pkg::TxData;
					txd_o <= shiftReg[0];	// lsb first
					bitIdx <= '0;
				end
				uart_pkg::TxData: if (bitDone) begin
					if (bitIdx == 3'd7) begin
						state <= cfg_i.parEn ? uart_pkg::TxParity : uart_pkg::TxStop;
						txd_o <= cfg_i.parEn ? parAcc ^ shiftReg[0] : 1'b1;
					end else begin
						bitIdx <= bitIdx + 1'b1;
						txd_o <= shiftReg[1];
					end
				end
				uart_pkg::TxParity: if (bitDone) begin
					state <= uart_pkg::TxStop;
					txd_o <= 1'b1;
				end
				uart_pkg::TxStop: if (bitDone) state <= uart_pkg::TxIdle;
				default: state <= uart_pkg::TxIdle;
			endcase
		end
	end

	// shift register and parity
	always_ff @(posedge clk_i) begin
		if (fifo.pop)
			shiftReg <= fifo.rdData;
		else if (state == uart_pkg::TxData && bitDone) begin
			shiftReg <= shiftReg >> 1;
			parAcc <= parAcc ^ shiftReg[0];
		end
		if (state == uart_pkg::TxStart && bitDone)
			parAcc <= cfg_i.parOdd;	// odd parity seeds a one
	end
endmodule

/* source/uart_baud_gen.sv */
`include "uart_consts.svh"

module uart_baud_gen (
	input logic clk_i,
	input logic rst_i,
	input uart_pkg::byte_t divisor_i,
	input logic restart_i,	// divisor just written
	output logic tick_o		// 16x bit rate
);
	uart_pkg::byte_t cnt;

	// ----------------------------------------
	// down counter, one tick per divisor+1 clocks
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt <= `UART_DIV_RESET;
			tick_o <= 1'b0;
		end else if (restart_i) begin
			cnt <= divisor_i;	// start a fresh period
			tick_o <= 1'b0;
		end else if (cnt == '0) begin
			cnt <= divisor_i;	// wrap
			tick_o <= 1'b1;
		end else begin
			cnt <= cnt - 1'b1;
			tick_o <= 1'b0;
		end
	end
endmodule

/* source/uart_regs.sv */
`include "uart_consts.svh"

module uart_regs (
	input logic clk_i,
	input logic rst_i,
	// host side, four-phase
	input logic req_i,
	output logic ack_o,
	input logic we_i,
	input logic [1:0] adr_i,
	input uart_pkg::byte_t dat_i,
	output uart_pkg::byte_t dat_o,
	// core side
	input logic txIdle_i,
	input logic overrun_i,		// one cycle pulse from rx
	uart_fifo_if.writer txFifo,
	uart_fifo_if.reader rxFifo,
	output uart_pkg::frame_cfg_t cfg_o,
	output logic loop_o,
	output uart_pkg::byte_t divisor_o,
	output logic divRestart_o
);
	logic reqQ;		// req sampled
	logic access;	// single cycle per transfer
	logic wr;
	logic rd;
	uart_pkg::frame_cfg_t cfg;
	logic loop;
	uart_pkg::byte_t divisor;
	logic overrun;	// sticky
	logic fifoClr;
	uart_pkg::byte_t stat;
	uart_pkg::byte_t readData;

	// ----------------------------------------
	// handshake
	// req seen at one edge, ack at the next; same delay on the way down
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			reqQ <= 1'b0;
			ack_o <= 1'b0;
		end else begin
			reqQ <= req_i;
			ack_o <= reqQ;
		end
	end

	assign access = reqQ & ~ack_o;
	assign wr = access & we_i;
	assign rd = access & ~we_i;

	// fifo strobes
	assign txFifo.push = wr && adr_i == `UART_ADDR_DATA;	// fifo drops it if full
	assign txFifo.wrData = dat_i;
	assign txFifo.clear = fifoClr;
	assign rxFifo.pop = rd && adr_i == `UART_ADDR_DATA && !rxFifo.empty;
	assign rxFifo.clear = fifoClr;

	// ----------------------------------------
	// read side
	always_comb begin
		stat = '0;
		stat[`UART_STAT_RXRDY] = ~rxFifo.empty;
		stat[`UART_STAT_TXFULL] = txFifo.full;
		stat[`UART_STAT_PERR] = ~rxFifo.empty & rxFifo.rdData.perr;	// head flags only
		stat[`UART_STAT_FERR] = ~rxFifo.empty & rxFifo.rdData.ferr;
		stat[`UART_STAT_OVR] = overrun;
		stat[`UART_STAT_TXIDLE] = txIdle_i;
	end

	always_comb begin
		readData = '0;
		case (adr_i)
			`UART_ADDR_DATA: readData = rxFifo.empty ? '0 : rxFifo.rdData.data;
			`UART_ADDR_STAT: readData = stat;
			`UART_ADDR_CMD: begin
				readData[`UART_CMD_PAREN] = cfg.parEn;
				readData[`UART_CMD_PARODD] = cfg.parOdd;
				readData[`UART_CMD_LOOP] = loop;	// fifo clear reads back 0
			end
			default: readData = divisor;
		endcase
	end

	// held while ack is up
	always_ff @(posedge clk_i) begin
		if (rd)
			dat_o <= readData;
	end

	// ----------------------------------------
	// write side
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cfg <= '0;
			loop <= 1'b0;
			divisor <= `UART_DIV_RESET;
			overrun <= 1'b0;
			fifoClr <= 1'b0;
			divRestart_o <= 1'b0;
		end else begin
			fifoClr <= 1'b0;		// pulses
			divRestart_o <= 1'b0;
			if (overrun_i)
				overrun <= 1'b1;	// a new overrun beats the clear
			else if (wr && adr_i == `UART_ADDR_STAT)
				overrun <= 1'b0;
			if (wr) begin
				case (adr_i)
					`UART_ADDR_CMD: begin
						cfg.parEn <= dat_i[`UART_CMD_PAREN];
						cfg.parOdd <= dat_i[`UART_CMD_PARODD];
						loop <= dat_i[`UART_CMD_LOOP];
						fifoClr <= dat_i[`UART_CMD_FIFOCLR];
					end
					`UART_ADDR_DIV: begin
						divisor <= dat_i;
						divRestart_o <= 1'b1;
					end
					default: ;	// data and stat handled above
				endcase
			end
		end
	end

	assign cfg_o = cfg;
	assign loop_o = loop;
	assign divisor_o = divisor;
endmodule

/* source/uart_fifo.sv */
`include "uart_consts.svh"

module uart_fifo #(
	parameter type entry_t = uart_pkg::byte_t
) (
	input logic clk_i,
	input logic rst_i,
	uart_fifo_if.fifo f
);
	localparam int Depth = `UART_FIFO_DEPTH;
	localparam int PtrW = $clog2(Depth);

	entry_t mem [Depth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [PtrW:0] count;	// occupancy, 0..Depth
	logic doPush;
	logic doPop;

	assign doPush = f.push & ~f.full;	// push when full dropped
	assign doPop = f.pop & ~f.empty;	// pop when empty dropped

	assign f.full = count == (PtrW + 1)'(Depth);
	assign f.empty = count == '0;
	assign f.rdData = mem[rdPtr];	// first word fall through

	// storage
	always_ff @(posedge clk_i) begin
		if (doPush)
			mem[wrPtr] <= f.wrData;
	end

	// ----------------------------------------
	// pointers and count
	always_ff @(posedge clk_i) begin
		if (rst_i || f.clear) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;	// both or neither, no change
			endcase
		end
	end
endmodule

/* source/uart_fifo_if.sv */
interface uart_fifo_if #(
	parameter type entry_t = uart_pkg::byte_t
);
	logic push;
	entry_t wrData;
	logic full;
	logic pop;
	entry_t rdData;		// head entry, valid while !empty
	logic empty;
	logic clear;		// flush, one cycle

	// producer side
	modport writer (
		output push, wrData, clear,
		input full
	);

	// consumer side, clear driven by whichever side owns the flush
	modport reader (
		output pop, clear,
		input rdData, empty
	);

	// the buffer itself
	modport fifo (
		input push, wrData, pop, clear,
		output full, rdData, empty
	);
endinterface

/* source/uart_pkg.sv */
package uart_pkg;

	// one data byte on the bus and on the line
	typedef logic [7:0] byte_t;

	// receive fifo entry, byte plus its line errors
	typedef struct packed {
		byte_t data;
		logic perr;	// parity mismatch
		logic ferr;	// stop bit sampled low
	} rx_entry_t;

	// frame format shared by tx and rx
	typedef struct packed {
		logic parEn;
		logic parOdd;	// 0 = even
	} frame_cfg_t;

	// ----------------------------------------
	// sequencer states
	typedef enum logic [2:0] {
		TxIdle, TxWait, TxStart, TxData, TxParity, TxStop
	} tx_state_t;

	typedef enum logic [2:0] {
		RxIdle, RxStart, RxData, RxParity, RxStop
	} rx_state_t;

endpackage

/* include/uart_consts.svh */
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// ----------------------------------------
// register map, 2 bit address
`define UART_ADDR_DATA		2'd0	// tx push / rx pop
`define UART_ADDR_STAT		2'd1
`define UART_ADDR_CMD		2'd2
`define UART_ADDR_DIV		2'd3	// baud divisor

// command register bits
`define UART_CMD_PAREN		0
`define UART_CMD_PARODD		1
`define UART_CMD_LOOP		2
`define UART_CMD_FIFOCLR	3	// self clearing

// status register bits
`define UART_STAT_RXRDY		0
`define UART_STAT_TXFULL	1
`define UART_STAT_PERR		2	// of the rx head entry
`define UART_STAT_FERR		3	// of the rx head entry
`define UART_STAT_OVR		4	// sticky
`define UART_STAT_TXIDLE	5

// ----------------------------------------
`define UART_FIFO_DEPTH		8
`define UART_DIV_RESET		8'd3	// tick every 4 clocks
`define UART_OVERSAMPLE		16	// ticks per bit

`endif
